// File: all.f
rtl/soc_pkg.sv
rtl/reg_bus_if.sv
rtl/periph_decoder.sv
rtl/clint.sv
rtl/plic.sv
rtl/gpio.sv
rtl/periph_soc.sv
test/tb_checker.sv
test/tb_top.sv

// File: rtl/clint.sv
module clint (
    input  logic      clk_i,
    input  logic      rst_i,
    reg_bus_if.periph bus,
    output logic      timer_irq_o,
    output logic      ipi_o
);
    import soc_pkg::*;

    logic  rtc;
    logic  msip;
    data_t mtime;
    data_t mtimecmp;
    logic  wr_en;

    assign wr_en = bus.sel & bus.we;

    //==================================================
    // Real-time tick
    //==================================================
    // Divides the clock by two
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            rtc <= 1'b0;
        end else begin
            rtc <= ~rtc;
        end
    end

    //==================================================
    // Timer registers
    //==================================================
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            mtime    <= '0;
            mtimecmp <= '1;
            msip     <= 1'b0;
        end else begin
            // Bus load wins over the tick
            if (wr_en && bus.ofs == MTIME_OFS) begin
                mtime <= bus.wdata;
            end else if (rtc) begin
                mtime <= mtime + 1'b1;
            end
            if (wr_en && bus.ofs == MTIMECMP_OFS) begin
                mtimecmp <= bus.wdata;
            end
            // Only bit 0 is implemented
            if (wr_en && bus.ofs == MSIP_OFS) begin
                msip <= bus.wdata[0];
            end
        end
    end

    // Registered compare
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            timer_irq_o <= 1'b0;
        end else begin
            timer_irq_o <= (mtime >= mtimecmp);
        end
    end

    assign ipi_o = msip;

    // Register readback
    always_comb begin
        case (bus.ofs)
            MSIP_OFS:     bus.rdata = data_t'(msip);
            MTIMECMP_OFS: bus.rdata = mtimecmp;
            MTIME_OFS:    bus.rdata = mtime;
            default:      bus.rdata = '0;
        endcase
    end

endmodule

// File: rtl/gpio.sv
module gpio (
    input  logic           clk_i,
    input  logic           rst_i,
    reg_bus_if.periph      bus,
    input  soc_pkg::gpio_t sw_i,
    output soc_pkg::gpio_t led_o,
    output logic           chg_o
);
    import soc_pkg::*;

    gpio_t sw_sync;
    gpio_t sw_prev;
    logic  primed;

    //==================================================
    // LED register
    //==================================================
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            led_o <= '0;
        end else if (bus.sel && bus.we && bus.ofs == LED_OFS) begin
            led_o <= bus.wdata[GPIO_W-1:0];
        end
    end

    //==================================================
    // Switch sampling and change detect
    //==================================================
    // First sample after reset loads both stages, so no false change
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            primed  <= 1'b0;
            sw_sync <= '0;
            sw_prev <= '0;
            chg_o   <= 1'b0;
        end else begin
            primed  <= 1'b1;
            sw_sync <= sw_i;
            sw_prev <= primed ? sw_sync : sw_i;
            chg_o   <= primed & (sw_sync != sw_prev);
        end
    end

    // Readback
    always_comb begin
        case (bus.ofs)
            LED_OFS: bus.rdata = data_t'(led_o);
            SW_OFS:  bus.rdata = data_t'(sw_sync);
            default: bus.rdata = '0;
        endcase
    end

endmodule

// File: rtl/periph_decoder.sv
module periph_decoder (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           req_i,
    input  logic           we_i,
    input  soc_pkg::addr_t addr_i,
    input  soc_pkg::data_t wdata_i,
    output soc_pkg::data_t rdata_o,
    output logic           rvalid_o,
    reg_bus_if.decoder     clint_bus,
    reg_bus_if.decoder     plic_bus,
    reg_bus_if.decoder     gpio_bus
);
    import soc_pkg::*;

    region_t region;
    offset_t ofs;
    logic    clint_hit;
    logic    plic_hit;
    logic    gpio_hit;
    data_t   rdata_mux;

    //==================================================
    // Region split
    //==================================================
    assign region    = addr_i[ADDR_W-1:REGION_LSB];
    assign ofs       = addr_i[REGION_LSB-1:0];

    // At most one hit, none for unmapped regions
    assign clint_hit = (region == REGION_CLINT);
    assign plic_hit  = (region == REGION_PLIC);
    assign gpio_hit  = (region == REGION_GPIO);

    // Strobes and shared request fields
    assign clint_bus.sel   = req_i & clint_hit;
    assign clint_bus.we    = we_i;
    assign clint_bus.ofs   = ofs;
    assign clint_bus.wdata = wdata_i;

    assign plic_bus.sel    = req_i & plic_hit;
    assign plic_bus.we     = we_i;
    assign plic_bus.ofs    = ofs;
    assign plic_bus.wdata  = wdata_i;

    assign gpio_bus.sel    = req_i & gpio_hit;
    assign gpio_bus.we     = we_i;
    assign gpio_bus.ofs    = ofs;
    assign gpio_bus.wdata  = wdata_i;

    //==================================================
    // Read return
    //==================================================
    // Unmapped reads give zero
    always_comb begin
        rdata_mux = '0;
        if (clint_hit) begin
            rdata_mux = clint_bus.rdata;
        end else if (plic_hit) begin
            rdata_mux = plic_bus.rdata;
        end else if (gpio_hit) begin
            rdata_mux = gpio_bus.rdata;
        end
    end

    // One cycle after the read strobe
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= req_i & ~we_i;
        end
    end

    // Data captured only on reads
    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            rdata_o <= rdata_mux;
        end
    end

endmodule

// File: rtl/periph_soc.sv
module periph_soc (
    input  logic                             clk_i,
    input  logic                             rst_i,
    // Register bus
    input  logic                             req_i,
    input  logic                             we_i,
    input  soc_pkg::addr_t                   addr_i,
    input  soc_pkg::data_t                   wdata_i,
    output soc_pkg::data_t                   rdata_o,
    output logic                             rvalid_o,
    // Interrupt sources and GPIO pins
    input  logic [soc_pkg::EXT_IRQ_NUM-1:0]  ext_irq_i,
    input  soc_pkg::gpio_t                   sw_i,
    output soc_pkg::gpio_t                   led_o,
    // Interrupts to the hart
    output logic                             timer_irq_o,
    output logic                             ipi_o,
    output logic                             ext_irq_o
);

    //==================================================
    // Peripheral ports
    //==================================================
    reg_bus_if clint_bus ();
    reg_bus_if plic_bus ();
    reg_bus_if gpio_bus ();

    // Switch change into PLIC source 1
    logic gpio_chg;

    periph_decoder u_decoder (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (req_i),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .rdata_o   (rdata_o),
        .rvalid_o  (rvalid_o),
        .clint_bus (clint_bus),
        .plic_bus  (plic_bus),
        .gpio_bus  (gpio_bus)
    );

    clint u_clint (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .bus         (clint_bus),
        .timer_irq_o (timer_irq_o),
        .ipi_o       (ipi_o)
    );

    // Sources 2 to 4 are the external lines, bit 0 unused
    plic u_plic (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus   (plic_bus),
        .src_i ({ext_irq_i, gpio_chg, 1'b0}),
        .irq_o (ext_irq_o)
    );

    gpio u_gpio (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus   (gpio_bus),
        .sw_i  (sw_i),
        .led_o (led_o),
        .chg_o (gpio_chg)
    );

endmodule

// File: rtl/plic.sv
module plic (
    input  logic             clk_i,
    input  logic             rst_i,
    reg_bus_if.periph        bus,
    input  soc_pkg::src_vec_t src_i,
    output logic             irq_o
);
    import soc_pkg::*;

    prio_t    prio [1:SRC_NUM];
    prio_t    threshold;
    src_vec_t enable;
    src_vec_t pending;
    src_vec_t in_service;
    src_id_t  claim_id;
    src_id_t  cmp_id;
    prio_t    best_prio;
    logic     wr_en;
    logic     claim_rd;
    logic     complete;

    //==================================================
    // Bus events
    //==================================================
    assign wr_en    = bus.sel & bus.we;
    // Reading the claim register has a side effect
    assign claim_rd = bus.sel & ~bus.we & (bus.ofs == CLAIM_OFS);
    assign complete = wr_en & (bus.ofs == CLAIM_OFS);
    assign cmp_id   = bus.wdata[$bits(src_id_t)-1:0];

    // Configuration registers
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 1; i <= SRC_NUM; i++) begin
                prio[i] <= '0;
            end
            threshold <= '0;
            enable    <= '0;
        end else if (wr_en) begin
            for (int i = 1; i <= SRC_NUM; i++) begin
                if (bus.ofs == offset_t'(PRIO_OFS + 4 * (i - 1))) begin
                    prio[i] <= bus.wdata[PRIO_W-1:0];
                end
            end
            if (bus.ofs == THRESHOLD_OFS) begin
                threshold <= bus.wdata[PRIO_W-1:0];
            end
            // Id 0 can never be enabled
            if (bus.ofs == ENABLE_OFS) begin
                enable <= {bus.wdata[SRC_NUM:1], 1'b0};
            end
        end
    end

    //==================================================
    // Gateways
    //==================================================
    // Claim moves a source from pending to in service,
    // complete releases it for the next rising level
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            pending    <= '0;
            in_service <= '0;
        end else begin
            for (int i = 1; i <= SRC_NUM; i++) begin
                if (claim_rd && claim_id == src_id_t'(i)) begin
                    pending[i]    <= 1'b0;
                    in_service[i] <= 1'b1;
                end else begin
                    if (src_i[i] && !in_service[i]) begin
                        pending[i] <= 1'b1;
                    end
                    if (complete && cmp_id == src_id_t'(i)) begin
                        in_service[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // Highest priority above threshold, ties to lowest id
    always_comb begin
        claim_id  = '0;
        best_prio = threshold;
        for (int i = 1; i <= SRC_NUM; i++) begin
            if (pending[i] && enable[i] && prio[i] > best_prio) begin
                claim_id  = src_id_t'(i);
                best_prio = prio[i];
            end
        end
    end

    assign irq_o = (claim_id != '0);

    // Register readback
    always_comb begin
        bus.rdata = '0;
        for (int i = 1; i <= SRC_NUM; i++) begin
            if (bus.ofs == offset_t'(PRIO_OFS + 4 * (i - 1))) begin
                bus.rdata = data_t'(prio[i]);
            end
        end
        case (bus.ofs)
            PENDING_OFS:   bus.rdata = data_t'(pending);
            ENABLE_OFS:    bus.rdata = data_t'(enable);
            THRESHOLD_OFS: bus.rdata = data_t'(threshold);
            CLAIM_OFS:     bus.rdata = data_t'(claim_id);
            default:       ;
        endcase
    end

endmodule

// File: rtl/reg_bus_if.sv
interface reg_bus_if;
    import soc_pkg::*;

    // Region strobe, one cycle per request
    logic    sel;
    logic    we;
    // Offset inside the region
    offset_t ofs;
    data_t   wdata;
    // Driven from the peripheral's current state
    data_t   rdata;

    modport decoder (
        output sel, we, ofs, wdata,
        input  rdata
    );

    modport periph (
        input  sel, we, ofs, wdata,
        output rdata
    );

endinterface

// File: rtl/soc_pkg.sv
package soc_pkg;

    //==================================================
    // Bus widths
    //==================================================
    localparam int ADDR_W     = 12;
    localparam int DATA_W     = 32;
    // Region field sits above the offset
    localparam int REGION_LSB = 8;
    localparam int REGION_W   = ADDR_W - REGION_LSB;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REGION_LSB-1:0] offset_t;
    typedef logic [REGION_W-1:0]   region_t;

    //==================================================
    // Address map
    //==================================================
    localparam region_t REGION_CLINT = 4'd0;
    localparam region_t REGION_PLIC  = 4'd1;
    localparam region_t REGION_GPIO  = 4'd2;

    // CLINT registers
    localparam offset_t MSIP_OFS      = 8'h00;
    localparam offset_t MTIMECMP_OFS  = 8'h04;
    localparam offset_t MTIME_OFS     = 8'h08;

    // PLIC registers, one priority word per source from PRIO_OFS
    localparam offset_t PRIO_OFS      = 8'h00;
    localparam offset_t PENDING_OFS   = 8'h10;
    localparam offset_t ENABLE_OFS    = 8'h14;
    localparam offset_t THRESHOLD_OFS = 8'h18;
    localparam offset_t CLAIM_OFS     = 8'h1C;

    // GPIO registers
    localparam offset_t LED_OFS       = 8'h00;
    localparam offset_t SW_OFS        = 8'h04;

    //==================================================
    // Interrupts and GPIO
    //==================================================
    localparam int SRC_NUM     = 4;
    localparam int EXT_IRQ_NUM = 3;
    localparam int PRIO_W      = 3;
    localparam int GPIO_W      = 8;

    // Bit 0 stays unused, id 0 means no interrupt
    typedef logic [SRC_NUM:0]               src_vec_t;
    typedef logic [$clog2(SRC_NUM+1)-1:0]   src_id_t;
    typedef logic [PRIO_W-1:0]              prio_t;
    typedef logic [GPIO_W-1:0]              gpio_t;

endpackage

// File: test/tb_checker.sv
module tb_checker (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            req_i,
    input  logic                            we_i,
    input  soc_pkg::addr_t                  addr_i,
    input  soc_pkg::data_t                  wdata_i,
    input  soc_pkg::data_t                  rdata_i,
    input  logic                            rvalid_i,
    input  logic [soc_pkg::EXT_IRQ_NUM-1:0] ext_irq_i,
    input  soc_pkg::gpio_t                  sw_i,
    input  soc_pkg::gpio_t                  led_i,
    input  logic                            ipi_i,
    input  logic                            timer_irq_i,
    input  logic                            irq_i,
    output int                              errors_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import soc_pkg::*;

    // Shadow of the writable registers
    logic     msip;
    data_t    mtimecmp;
    gpio_t    led;
    prio_t    prio [1:SRC_NUM];
    prio_t    threshold;
    src_vec_t enable;
    // Gateway state
    src_vec_t pending;
    src_vec_t in_service;
    // Switch path into source 1
    gpio_t    sw_s;
    gpio_t    sw_p;
    logic     chg;
    // Read in flight until the next falling edge
    logic     rd_pend;
    logic     rd_mtime;
    data_t    rd_exp;
    addr_t    rd_addr;
    data_t    last_mtime = '0;
    logic     claim_rd;
    logic     complete;
    src_id_t  id_now;
    src_vec_t src_now;
    int       errors = 0;

    assign errors_o = errors;
    assign claim_rd = req_i & ~we_i & (addr_i == {REGION_PLIC, CLAIM_OFS});
    assign complete = req_i & we_i & (addr_i == {REGION_PLIC, CLAIM_OFS});

    //==================================================
    // Reference model
    //==================================================
    // Scan from the top priority down with lowest id first
    function automatic src_id_t claim_ref();
        for (int p = 7; p > int'(threshold); p--) begin
            for (int i = 1; i <= SRC_NUM; i++) begin
                if (pending[i] && enable[i] && int'(prio[i]) == p) begin
                    return src_id_t'(i);
                end
            end
        end
        return '0;
    endfunction

    function automatic data_t rdata_ref(addr_t a);
        offset_t o;
        o = a[REGION_LSB-1:0];
        case (a[ADDR_W-1:REGION_LSB])
            REGION_CLINT: begin
                case (o)
                    MSIP_OFS:     return data_t'(msip);
                    MTIMECMP_OFS: return mtimecmp;
                    default:      return '0;
                endcase
            end
            REGION_PLIC: begin
                case (o)
                    PENDING_OFS:   return data_t'(pending);
                    ENABLE_OFS:    return data_t'(enable);
                    THRESHOLD_OFS: return data_t'(threshold);
                    CLAIM_OFS:     return data_t'(claim_ref());
                    default: begin
                        // Word-aligned priority slots below PENDING_OFS
                        if (o < PENDING_OFS && o[1:0] == 2'b00) begin
                            return data_t'(prio[o[3:2] + 1]);
                        end
                        return '0;
                    end
                endcase
            end
            REGION_GPIO: begin
                case (o)
                    LED_OFS: return data_t'(led);
                    SW_OFS:  return data_t'(sw_s);
                    default: return '0;
                endcase
            end
            default: return '0;
        endcase
    endfunction

    task automatic flag_mismatch(input string sig, input data_t got, input data_t exp);
        $display("[FAIL] %s: got %h, expected %h", sig, got, exp);
        errors++;
    endtask

    //==================================================
    // Shadow update on the rising edge
    //==================================================
    always @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            msip       <= 1'b0;
            mtimecmp   <= '1;
            led        <= '0;
            threshold  <= '0;
            enable     <= '0;
            pending    <= '0;
            in_service <= '0;
            sw_s       <= '0;
            sw_p       <= '0;
            chg        <= 1'b0;
            rd_pend    <= 1'b0;
            for (int i = 1; i <= SRC_NUM; i++) begin
                prio[i] <= '0;
            end
        end else begin
            // Values seen before this edge
            id_now  = claim_ref();
            src_now = {ext_irq_i, chg, 1'b0};
            rd_pend  <= req_i & ~we_i;
            rd_mtime <= (addr_i == {REGION_CLINT, MTIME_OFS});
            rd_exp   <= rdata_ref(addr_i);
            rd_addr  <= addr_i;
            if (req_i && we_i) begin
                case (addr_i)
                    {REGION_CLINT, MSIP_OFS}:     msip      <= wdata_i[0];
                    {REGION_CLINT, MTIMECMP_OFS}: mtimecmp  <= wdata_i;
                    {REGION_GPIO, LED_OFS}:       led       <= wdata_i[GPIO_W-1:0];
                    {REGION_PLIC, ENABLE_OFS}:    enable    <= {wdata_i[SRC_NUM:1], 1'b0};
                    {REGION_PLIC, THRESHOLD_OFS}: threshold <= wdata_i[PRIO_W-1:0];
                    default: ;
                endcase
                for (int i = 1; i <= SRC_NUM; i++) begin
                    if (addr_i == {REGION_PLIC, offset_t'(PRIO_OFS + 4 * (i - 1))}) begin
                        prio[i] <= wdata_i[PRIO_W-1:0];
                    end
                end
            end
            // Switch sync stage and change pulse
            sw_s <= sw_i;
            sw_p <= sw_s;
            chg  <= (sw_s != sw_p);
            for (int i = 1; i <= SRC_NUM; i++) begin
                if (claim_rd && id_now == src_id_t'(i)) begin
                    pending[i]    <= 1'b0;
                    in_service[i] <= 1'b1;
                end else begin
                    if (src_now[i] && !in_service[i]) begin
                        pending[i] <= 1'b1;
                    end
                    if (complete && wdata_i[$bits(src_id_t)-1:0] == src_id_t'(i)) begin
                        in_service[i] <= 1'b0;
                    end
                end
            end
        end
    end

    //==================================================
    // Compare on the falling edge
    //==================================================
    always @(negedge clk_i) begin
        if (rst_i) begin
            if (rvalid_i !== rd_pend) begin
                flag_mismatch("rvalid_o", data_t'(rvalid_i), data_t'(rd_pend));
            end else if (rd_pend && rd_mtime) begin
                // mtime never moves backwards
                if (rdata_i < last_mtime) begin
                    flag_mismatch("rdata_o at mtime", rdata_i, last_mtime);
                end
                last_mtime = rdata_i;
                // Timer compare registered at the edge that sampled this mtime
                if (timer_irq_i !== (rdata_i >= mtimecmp)) begin
                    flag_mismatch("timer_irq_o", data_t'(timer_irq_i),
                                  data_t'(rdata_i >= mtimecmp));
                end
            end else if (rd_pend && rdata_i !== rd_exp) begin
                flag_mismatch($sformatf("rdata_o at %h", rd_addr), rdata_i, rd_exp);
            end
            if (led_i !== led) begin
                flag_mismatch("led_o", data_t'(led_i), data_t'(led));
            end
            if (ipi_i !== msip) begin
                flag_mismatch("ipi_o", data_t'(ipi_i), data_t'(msip));
            end
            if (irq_i !== (claim_ref() != '0)) begin
                flag_mismatch("ext_irq_o", data_t'(irq_i), data_t'(claim_ref() != '0));
            end
        end
    end

endmodule

// File: test/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import soc_pkg::*;

    logic                   clk_i;
    logic                   rst_i;
    logic                   req_i;
    logic                   we_i;
    addr_t                  addr_i;
    data_t                  wdata_i;
    data_t                  rdata_o;
    logic                   rvalid_o;
    logic [EXT_IRQ_NUM-1:0] ext_irq_i;
    gpio_t                  sw_i;
    gpio_t                  led_o;
    logic                   timer_irq_o;
    logic                   ipi_o;
    logic                   ext_irq_o;
    int                     chk_errors;
    int                     tb_errors;
    int                     timeouts;
    integer                 seed;
    data_t                  rd;
    data_t                  cmp;

    // 100 ns period
    always #50 clk_i = ~clk_i;

    periph_soc dut0 (.*);

    tb_checker chk0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rdata_i     (rdata_o),
        .rvalid_i    (rvalid_o),
        .ext_irq_i   (ext_irq_i),
        .sw_i        (sw_i),
        .led_i       (led_o),
        .ipi_i       (ipi_o),
        .timer_irq_i (timer_irq_o),
        .irq_i       (ext_irq_o),
        .errors_o    (chk_errors)
    );

    //==================================================
    // Bus access
    //==================================================
    function automatic addr_t reg_addr(region_t r, offset_t o);
        return {r, o};
    endfunction

    task automatic bus_write(input addr_t a, input data_t d);
        @(negedge clk_i);
        req_i   = 1'b1;
        we_i    = 1'b1;
        addr_i  = a;
        wdata_i = d;
        @(negedge clk_i);
        req_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic bus_read(input addr_t a, output data_t d);
        int k;
        @(negedge clk_i);
        req_i  = 1'b1;
        we_i   = 1'b0;
        addr_i = a;
        @(negedge clk_i);
        req_i = 1'b0;
        k = 0;
        while (!rvalid_o && k < 16) begin
            @(negedge clk_i);
            k++;
        end
        if (!rvalid_o) begin
            $display("Timeout: no read response for address %h", a);
            timeouts++;
        end
        d = rdata_o;
    endtask

    // Waits on ext_irq_o when sel is high and on timer_irq_o otherwise
    task automatic wait_irq(input bit sel, input string what);
        int k;
        k = 0;
        while (!(sel ? ext_irq_o : timer_irq_o) && k < 200) begin
            @(negedge clk_i);
            k++;
        end
        if (!(sel ? ext_irq_o : timer_irq_o)) begin
            $display("Timeout: %s never rose", what);
            timeouts++;
        end
    endtask

    initial begin
        seed      = 67189;
        tb_errors = 0;
        timeouts  = 0;
        clk_i     = 1'b0;
        rst_i     = 1'b0;
        req_i     = 1'b0;
        we_i      = 1'b0;
        addr_i    = '0;
        wdata_i   = '0;
        ext_irq_i = '0;
        sw_i      = '0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b1;

        // LED writes and switch readback after the sync stage
        for (int n = 0; n < 8; n++) begin
            bus_write(reg_addr(REGION_GPIO, LED_OFS), $random(seed));
            bus_read(reg_addr(REGION_GPIO, LED_OFS), rd);
            sw_i = gpio_t'($random(seed));
            repeat (2) @(negedge clk_i);
            bus_read(reg_addr(REGION_GPIO, SW_OFS), rd);
        end

        // Unmapped accesses leave mapped registers untouched
        for (int r = 3; r < 16; r++) begin
            bus_write(reg_addr(region_t'(r), offset_t'(4 * (r % 3))), $random(seed));
            bus_read(reg_addr(region_t'(r), offset_t'(4 * (r % 3))), rd);
        end
        bus_read(reg_addr(REGION_GPIO, LED_OFS), rd);
        bus_read(reg_addr(REGION_CLINT, MTIMECMP_OFS), rd);
        bus_read(reg_addr(REGION_CLINT, MSIP_OFS), rd);

        //==================================================
        // CLINT
        //==================================================
        bus_read(reg_addr(REGION_CLINT, MTIME_OFS), rd);
        bus_read(reg_addr(REGION_CLINT, MTIME_OFS), rd);
        cmp = rd + 20;
        bus_write(reg_addr(REGION_CLINT, MTIMECMP_OFS), cmp);
        wait_irq(1'b0, "timer_irq_o");
        bus_read(reg_addr(REGION_CLINT, MTIME_OFS), rd);
        if (rd < cmp) begin
            $display("[FAIL] mtime: got %h, expected at least %h", rd, cmp);
            tb_errors++;
        end
        bus_write(reg_addr(REGION_CLINT, MSIP_OFS), 32'h1);
        bus_read(reg_addr(REGION_CLINT, MSIP_OFS), rd);
        bus_write(reg_addr(REGION_CLINT, MSIP_OFS), 32'h0);

        //==================================================
        // PLIC claim order
        //==================================================
        for (int n = 0; n < 6; n++) begin
            for (int s = 1; s <= SRC_NUM; s++) begin
                bus_write({REGION_PLIC, offset_t'(PRIO_OFS + 4 * (s - 1))}, $random(seed));
            end
            bus_write(reg_addr(REGION_PLIC, ENABLE_OFS), $random(seed));
            bus_write(reg_addr(REGION_PLIC, THRESHOLD_OFS), $random(seed) & 3);
            ext_irq_i = $random(seed);
            repeat (3) @(negedge clk_i);
            bus_read(reg_addr(REGION_PLIC, PENDING_OFS), rd);
            bus_read(reg_addr(REGION_PLIC, CLAIM_OFS), cmp);
            ext_irq_i = '0;
            repeat (2) @(negedge clk_i);
            bus_read(reg_addr(REGION_PLIC, PENDING_OFS), rd);
            bus_write(reg_addr(REGION_PLIC, CLAIM_OFS), cmp);
        end
        // Completed sources pend again
        ext_irq_i = '1;
        repeat (3) @(negedge clk_i);
        bus_read(reg_addr(REGION_PLIC, PENDING_OFS), rd);
        ext_irq_i = '0;

        // GPIO change as source 1 at top priority
        bus_write(reg_addr(REGION_PLIC, PRIO_OFS), 32'd7);
        bus_write(reg_addr(REGION_PLIC, ENABLE_OFS), 32'h2);
        bus_write(reg_addr(REGION_PLIC, THRESHOLD_OFS), 32'd0);
        // Drain an earlier switch change
        bus_read(reg_addr(REGION_PLIC, CLAIM_OFS), rd);
        bus_write(reg_addr(REGION_PLIC, CLAIM_OFS), rd);
        sw_i = ~sw_i;
        wait_irq(1'b1, "ext_irq_o");
        bus_read(reg_addr(REGION_PLIC, PENDING_OFS), rd);
        bus_read(reg_addr(REGION_PLIC, CLAIM_OFS), rd);
        if (rd !== 32'd1) begin
            $display("[FAIL] claim id: got %h, expected %h", rd, 32'd1);
            tb_errors++;
        end
        bus_write(reg_addr(REGION_PLIC, CLAIM_OFS), rd);

        repeat (2) @(negedge clk_i);
        $display("Errors: checker %0d, testbench %0d, timeouts %0d",
                 chk_errors, tb_errors, timeouts);
        if (chk_errors + tb_errors + timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
